//--- laser_link_pkg.sv
package laser_link_pkg;

    // Clock cycles in one bit period
    localparam int BIT_TICKS = 8;
    localparam int TICK_WIDTH = 4;

    // Three-sample vote window inside a bit period
    localparam int VOTE_FIRST = 3;
    localparam int VOTE_LAST = 5;

    // Frame layout: start bit, data bits, stop bit
    localparam int DATA_BITS = 8;
    localparam int FRAME_BITS = 10;
    localparam int FRAME_CNT_WIDTH = 4;

    // Line levels of the framing bits
    localparam logic START_LEVEL = 1'b1;
    localparam logic STOP_LEVEL = 1'b0;

    // Count within a bit period
    typedef logic [TICK_WIDTH-1:0] tick_t;

    // Count of bit periods within a frame
    typedef logic [FRAME_CNT_WIDTH-1:0] bit_cnt_t;

    // One byte per laser
    typedef struct packed {
        logic [DATA_BITS-1:0] lane1;
        logic [DATA_BITS-1:0] lane2;
    } lane_pair_t;

endpackage

//--- bit_timing_if.sv
`timescale 1ns/100ps

interface bit_timing_if;

    // Strobes decoded from the bit timer count
    logic vote;
    logic sample;
    logic bit_end;

    // Holds the timer at zero while high
    logic restart;

    modport timer (
        output vote,
        output sample,
        output bit_end,
        input  restart
    );

    modport user (
        input  vote,
        input  sample,
        input  bit_end,
        output restart
    );

endinterface

//--- bit_timer.sv
`timescale 1ns/100ps

module bit_timer (
    input  logic        clock,
    input  logic        reset,
    bit_timing_if.timer timing
);

    laser_link_pkg::tick_t count;

    // Free-running count, wraps at the end of each bit period
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (timing.restart) begin
            count <= '0;
        end else if (timing.bit_end) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // Middle of the bit, three cycles wide
    assign timing.vote =
        (count >= laser_link_pkg::tick_t'(laser_link_pkg::VOTE_FIRST)) &&
        (count <= laser_link_pkg::tick_t'(laser_link_pkg::VOTE_LAST));

    // Decision point right after the window
    assign timing.sample =
        (count == laser_link_pkg::tick_t'(laser_link_pkg::VOTE_LAST + 1));

    assign timing.bit_end =
        (count == laser_link_pkg::tick_t'(laser_link_pkg::BIT_TICKS - 1));

    // The wrap must keep the count inside one bit period
    a_count_in_range: assert property (
        @(posedge clock) disable iff (reset)
        count < laser_link_pkg::tick_t'(laser_link_pkg::BIT_TICKS)
    );

endmodule

//--- tx_sequencer.sv
`timescale 1ns/100ps

module tx_sequencer (
    input  logic       clock,
    input  logic       reset,
    input  logic       en,
    input  logic       tx_start,
    bit_timing_if.user timing,
    output logic       load,
    output logic       shift,
    output logic       busy,
    output logic       tx_done
);

    typedef enum logic {
        IDLE,
        SEND
    } state_t;

    state_t state;
    state_t state_next;
    laser_link_pkg::bit_cnt_t bit_cnt;
    logic last_bit;

    // End of the stop bit
    assign last_bit = timing.bit_end &&
        (bit_cnt == laser_link_pkg::bit_cnt_t'(laser_link_pkg::FRAME_BITS - 1));

    assign busy = (state == SEND);

    // One pair in flight, a start while busy is ignored
    assign load = (state == IDLE) && tx_start && en;
    assign shift = busy && timing.bit_end;
    assign tx_done = en && last_bit;

    // Keep the timer at zero so the first bit gets a full period
    assign timing.restart = (state == IDLE);

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (load) begin
                    state_next = SEND;
                end
            end
            SEND: begin
                // Dropping en aborts the frame
                if (!en || last_bit) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state <= IDLE;
            bit_cnt <= '0;
        end else begin
            state <= state_next;
            // Cleared on every way out of SEND, so the count is zero in IDLE
            if (state != SEND || state_next != SEND) begin
                bit_cnt <= '0;
            end else if (timing.bit_end) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // Done only in SEND, and the frame ends on the following edge
    a_done_in_send: assert property (
        @(posedge clock) disable iff (reset)
        tx_done |-> busy ##1 !busy
    );

endmodule

//--- frame_serializer.sv
`timescale 1ns/100ps

module frame_serializer (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       load,
    input  logic                       shift,
    input  logic                       busy,
    input  laser_link_pkg::lane_pair_t pair,
    output logic                       laser1_tx,
    output logic                       laser2_tx
);

    logic [laser_link_pkg::FRAME_BITS-1:0] frame1;
    logic [laser_link_pkg::FRAME_BITS-1:0] frame2;

    // Start bit at the bottom so it goes out first, data LSB first
    function automatic logic [laser_link_pkg::FRAME_BITS-1:0] build_frame(
        input logic [laser_link_pkg::DATA_BITS-1:0] data
    );
        return {laser_link_pkg::STOP_LEVEL, data, laser_link_pkg::START_LEVEL};
    endfunction

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            frame1 <= '0;
            frame2 <= '0;
        end else if (load) begin
            frame1 <= build_frame(pair.lane1);
            frame2 <= build_frame(pair.lane2);
        end else if (shift) begin
            frame1 <= {laser_link_pkg::STOP_LEVEL, frame1[laser_link_pkg::FRAME_BITS-1:1]};
            frame2 <= {laser_link_pkg::STOP_LEVEL, frame2[laser_link_pkg::FRAME_BITS-1:1]};
        end
    end

    // Line stays low whenever no frame is going out
    assign laser1_tx = frame1[0] & busy;
    assign laser2_tx = frame2[0] & busy;

endmodule

//--- rx_lane_sampler.sv
`timescale 1ns/100ps

module rx_lane_sampler (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  line,
    bit_timing_if.user                            timing,
    output logic [laser_link_pkg::FRAME_BITS-1:0] frame
);

    logic [1:0] vote_cnt;
    logic decided;

    // Two or more of the three samples high
    assign decided = vote_cnt[1];

    // High samples seen in the current window
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            vote_cnt <= '0;
        end else if (timing.sample) begin
            vote_cnt <= '0;
        end else if (timing.vote && line) begin
            vote_cnt <= vote_cnt + 1'b1;
        end
    end

    // Shift in from the top, so after a full frame the start bit is at bit 0
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            frame <= '0;
        end else if (timing.sample) begin
            frame <= {decided, frame[laser_link_pkg::FRAME_BITS-1:1]};
        end
    end

endmodule

//--- rx_framer.sv
`timescale 1ns/100ps

module rx_framer (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  laser1_rx,
    input  logic                                  laser2_rx,
    bit_timing_if.user                            timing,
    input  logic [laser_link_pkg::FRAME_BITS-1:0] frame1,
    input  logic [laser_link_pkg::FRAME_BITS-1:0] frame2,
    output logic                                  line1,
    output logic                                  line2,
    output logic                                  rx_valid,
    output laser_link_pkg::lane_pair_t            rx_pair
);

    typedef enum logic {
        IDLE,
        RECEIVE
    } state_t;

    state_t state;
    state_t state_next;
    laser_link_pkg::bit_cnt_t bit_cnt;
    logic meta1;
    logic meta2;
    logic prev1;
    logic prev2;
    logic rise;
    logic frame_end;
    logic frame_ok;

    // Two-flop synchronizer per lane, plus one more flop for edge detect
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            meta1 <= 1'b0;
            meta2 <= 1'b0;
            line1 <= 1'b0;
            line2 <= 1'b0;
            prev1 <= 1'b0;
            prev2 <= 1'b0;
        end else begin
            meta1 <= laser1_rx;
            meta2 <= laser2_rx;
            line1 <= meta1;
            line2 <= meta2;
            prev1 <= line1;
            prev2 <= line2;
        end
    end

    assign rise = (line1 & ~prev1) | (line2 & ~prev2);

    // Timer is released on the rising edge, that cycle is the first of bit one
    assign timing.restart = (state == IDLE) && !rise;

    assign frame_end = (state == RECEIVE) && timing.bit_end &&
        (bit_cnt == laser_link_pkg::bit_cnt_t'(laser_link_pkg::FRAME_BITS - 1));

    // Both lanes need a proper start and stop bit
    assign frame_ok =
        (frame1[0] == laser_link_pkg::START_LEVEL) &&
        (frame2[0] == laser_link_pkg::START_LEVEL) &&
        (frame1[laser_link_pkg::FRAME_BITS-1] == laser_link_pkg::STOP_LEVEL) &&
        (frame2[laser_link_pkg::FRAME_BITS-1] == laser_link_pkg::STOP_LEVEL);

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (rise) begin
                    state_next = RECEIVE;
                end
            end
            RECEIVE: begin
                if (frame_end) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state <= IDLE;
            bit_cnt <= '0;
        end else begin
            state <= state_next;
            if (state != RECEIVE) begin
                bit_cnt <= '0;
            end else if (timing.bit_end) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // Bytes sit between the framing bits, bad frames are dropped silently
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            rx_valid <= 1'b0;
            rx_pair <= '0;
        end else begin
            rx_valid <= frame_end && frame_ok;
            if (frame_end && frame_ok) begin
                rx_pair.lane1 <= frame1[laser_link_pkg::DATA_BITS:1];
                rx_pair.lane2 <= frame2[laser_link_pkg::DATA_BITS:1];
            end
        end
    end

    // A frame takes many cycles, so valid can never repeat back to back
    a_valid_single: assert property (
        @(posedge clock) disable iff (reset)
        rx_valid |=> !rx_valid
    );

endmodule

//--- laser_link.sv
`timescale 1ns/100ps

module laser_link (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 en,
    input  logic                                 tx_start,
    input  logic [laser_link_pkg::DATA_BITS-1:0] tx_data1,
    input  logic [laser_link_pkg::DATA_BITS-1:0] tx_data2,
    output logic                                 tx_busy,
    output logic                                 tx_done,
    output logic                                 laser1_tx,
    output logic                                 laser2_tx,
    input  logic                                 laser1_rx,
    input  logic                                 laser2_rx,
    output logic                                 rx_valid,
    output logic [laser_link_pkg::DATA_BITS-1:0] rx_data1,
    output logic [laser_link_pkg::DATA_BITS-1:0] rx_data2
);

    bit_timing_if tx_timing ();
    bit_timing_if rx_timing ();

    logic load;
    logic shift;
    logic line1;
    logic line2;
    logic [laser_link_pkg::FRAME_BITS-1:0] frame1;
    logic [laser_link_pkg::FRAME_BITS-1:0] frame2;
    laser_link_pkg::lane_pair_t tx_pair;
    laser_link_pkg::lane_pair_t rx_pair;

    assign tx_pair.lane1 = tx_data1;
    assign tx_pair.lane2 = tx_data2;
    assign rx_data1 = rx_pair.lane1;
    assign rx_data2 = rx_pair.lane2;

    // Transmit path
    bit_timer tx_timer (
        .clock  (clock),
        .reset  (reset),
        .timing (tx_timing.timer)
    );

    tx_sequencer tx_seq (
        .clock    (clock),
        .reset    (reset),
        .en       (en),
        .tx_start (tx_start),
        .timing   (tx_timing.user),
        .load     (load),
        .shift    (shift),
        .busy     (tx_busy),
        .tx_done  (tx_done)
    );

    frame_serializer tx_ser (
        .clock     (clock),
        .reset     (reset),
        .load      (load),
        .shift     (shift),
        .busy      (tx_busy),
        .pair      (tx_pair),
        .laser1_tx (laser1_tx),
        .laser2_tx (laser2_tx)
    );

    // Receive path, one timer shared by both lanes
    bit_timer rx_timer (
        .clock  (clock),
        .reset  (reset),
        .timing (rx_timing.timer)
    );

    rx_lane_sampler rx_lane1 (
        .clock  (clock),
        .reset  (reset),
        .line   (line1),
        .timing (rx_timing.user),
        .frame  (frame1)
    );

    rx_lane_sampler rx_lane2 (
        .clock  (clock),
        .reset  (reset),
        .line   (line2),
        .timing (rx_timing.user),
        .frame  (frame2)
    );

    rx_framer rx_frm (
        .clock     (clock),
        .reset     (reset),
        .laser1_rx (laser1_rx),
        .laser2_rx (laser2_rx),
        .timing    (rx_timing.user),
        .frame1    (frame1),
        .frame2    (frame2),
        .line1     (line1),
        .line2     (line2),
        .rx_valid  (rx_valid),
        .rx_pair   (rx_pair)
    );

endmodule

//--- laser_link_tb.sv
`timescale 1ns/100ps

module laser_link_tb;

    localparam int FRAME_CYCLES = laser_link_pkg::FRAME_BITS * laser_link_pkg::BIT_TICKS;
    localparam int RESET_CYCLES = 2;
    // Frames over all tests, the aborted one included
    localparam int TOTAL_FRAMES = 26;
    localparam int CYCLE_LIMIT = (3 * TOTAL_FRAMES * FRAME_CYCLES) / 2 + RESET_CYCLES;
    // Low cycles after a driven frame, long enough for its rx_valid to come out
    localparam int IDLE_GAP = 6;
    localparam int NO_GLITCH = -1;

    logic clock;
    logic reset;
    logic en;
    logic tx_start;
    logic [laser_link_pkg::DATA_BITS-1:0] tx_data1;
    logic [laser_link_pkg::DATA_BITS-1:0] tx_data2;
    logic tx_busy;
    logic tx_done;
    logic laser1_tx;
    logic laser2_tx;
    logic laser1_rx;
    logic laser2_rx;
    logic rx_valid;
    logic [laser_link_pkg::DATA_BITS-1:0] rx_data1;
    logic [laser_link_pkg::DATA_BITS-1:0] rx_data2;

    // Receive line selector, loopback or directly driven frames
    logic loopback;
    logic drive1;
    logic drive2;

    laser_link_pkg::lane_pair_t expected_q[$];
    laser_link_pkg::lane_pair_t want;
    logic [15:0] lfsr_state;
    string test_name = "reset";
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int base_errors = 0;
    int busy_cycles = 0;
    int done_count = 0;
    int cycle_count = 0;

    assign laser1_rx = loopback ? laser1_tx : drive1;
    assign laser2_rx = loopback ? laser2_tx : drive2;

    laser_link dut (
        .clock     (clock),
        .reset     (reset),
        .en        (en),
        .tx_start  (tx_start),
        .tx_data1  (tx_data1),
        .tx_data2  (tx_data2),
        .tx_busy   (tx_busy),
        .tx_done   (tx_done),
        .laser1_tx (laser1_tx),
        .laser2_tx (laser2_tx),
        .laser1_rx (laser1_rx),
        .laser2_rx (laser2_rx),
        .rx_valid  (rx_valid),
        .rx_data1  (rx_data1),
        .rx_data2  (rx_data2)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // Lane frame as it goes out, bit 0 first
    function automatic logic [laser_link_pkg::FRAME_BITS-1:0] make_frame(
        input logic [laser_link_pkg::DATA_BITS-1:0] data,
        input logic start_bit,
        input logic stop_bit
    );
        return {stop_bit, data, start_bit};
    endfunction

    // Reference model of the receiver: accept only good framing on both lanes
    function automatic logic expect_frame(
        input  logic [laser_link_pkg::FRAME_BITS-1:0] f1,
        input  logic [laser_link_pkg::FRAME_BITS-1:0] f2,
        output laser_link_pkg::lane_pair_t            pair
    );
        pair.lane1 = f1[laser_link_pkg::DATA_BITS:1];
        pair.lane2 = f2[laser_link_pkg::DATA_BITS:1];
        return (f1[0] == laser_link_pkg::START_LEVEL) && (f2[0] == laser_link_pkg::START_LEVEL) &&
            (f1[laser_link_pkg::FRAME_BITS-1] == laser_link_pkg::STOP_LEVEL) &&
            (f2[laser_link_pkg::FRAME_BITS-1] == laser_link_pkg::STOP_LEVEL);
    endfunction

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic random_byte(output logic [laser_link_pkg::DATA_BITS-1:0] value);
        for (int i = 0; i < laser_link_pkg::DATA_BITS; i++) begin
            value[i] = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic check_int(input string what, input int expected, input int actual);
        checks++;
        assert (actual == expected) else begin
            $display("FAILED %s %s expected %0d actual %0d", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        base_errors = errors;
        busy_cycles = 0;
        done_count = 0;
    endtask

    task automatic end_test();
        tests++;
        $display("%-16s %s, %0d errors", test_name,
            (errors == base_errors) ? "ok" : "FAIL", errors - base_errors);
    endtask

    // Wait for every queued pair to arrive, the cycle limit catches a loss
    task automatic wait_received();
        while (expected_q.size() > 0) begin
            @(negedge clock);
        end
        repeat (IDLE_GAP) @(negedge clock);
    endtask

    // Send a pair in loopback, optionally with a second start while busy
    task automatic send_pair(
        input logic [laser_link_pkg::DATA_BITS-1:0] d1,
        input logic [laser_link_pkg::DATA_BITS-1:0] d2,
        input logic poke
    );
        laser_link_pkg::lane_pair_t pair;
        logic valid;
        valid = expect_frame(
            make_frame(d1, laser_link_pkg::START_LEVEL, laser_link_pkg::STOP_LEVEL),
            make_frame(d2, laser_link_pkg::START_LEVEL, laser_link_pkg::STOP_LEVEL), pair);
        if (valid) begin
            expected_q.push_back(pair);
        end
        tx_data1 = d1;
        tx_data2 = d2;
        tx_start = 1'b1;
        @(negedge clock);
        tx_start = 1'b0;
        check_int("tx_busy after start", 1, int'(tx_busy));
        if (poke) begin
            repeat (FRAME_CYCLES / 2) @(negedge clock);
            tx_data1 = ~d1;
            tx_data2 = ~d2;
            tx_start = 1'b1;
            @(negedge clock);
            tx_start = 1'b0;
        end
        while (tx_busy) begin
            @(negedge clock);
        end
    endtask

    // Drive both receive lines directly, a glitch flips lane 1 mid-bit for one cycle
    task automatic drive_frames(
        input logic [laser_link_pkg::FRAME_BITS-1:0] f1,
        input logic [laser_link_pkg::FRAME_BITS-1:0] f2,
        input int glitch_bit
    );
        laser_link_pkg::lane_pair_t pair;
        logic valid;
        valid = expect_frame(f1, f2, pair);
        if (valid) begin
            expected_q.push_back(pair);
        end
        for (int b = 0; b < laser_link_pkg::FRAME_BITS; b++) begin
            for (int t = 0; t < laser_link_pkg::BIT_TICKS; t++) begin
                drive1 = f1[b] ^ ((b == glitch_bit) && (t == laser_link_pkg::BIT_TICKS / 2));
                drive2 = f2[b];
                @(negedge clock);
            end
        end
        drive1 = 1'b0;
        drive2 = 1'b0;
        repeat (IDLE_GAP) @(negedge clock);
    endtask

    // Comparison process, outputs are stable at the falling edge
    always @(negedge clock) begin
        if (!reset && rx_valid) begin
            checks++;
            assert (expected_q.size() > 0) else begin
                $display("%s: rx_valid arrived with no frame expected", test_name);
                errors++;
            end
            if (expected_q.size() > 0) begin
                want = expected_q.pop_front();
                assert ({rx_data1, rx_data2} == want) else begin
                    $display("FAILED %s rx pair expected %h actual %h",
                        test_name, want, {rx_data1, rx_data2});
                    errors++;
                end
            end
        end
    end

    always @(negedge clock) begin
        if (!reset) begin
            if (tx_busy) begin
                busy_cycles++;
            end
            if (tx_done) begin
                done_count++;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles in %s, the DUT stopped responding",
                cycle_count, test_name);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        logic [laser_link_pkg::DATA_BITS-1:0] d1;
        logic [laser_link_pkg::DATA_BITS-1:0] d2;
        reset = 1'b1;
        en = 1'b0;
        tx_start = 1'b0;
        tx_data1 = '0;
        tx_data2 = '0;
        loopback = 1'b1;
        drive1 = 1'b0;
        drive2 = 1'b0;
        lfsr_state = 16'd21;
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;
        en = 1'b1;

        begin_test("reset");
        check_int("tx_busy", 0, int'(tx_busy));
        check_int("tx_done", 0, int'(tx_done));
        check_int("rx_valid", 0, int'(rx_valid));
        check_int("lasers", 0, int'({laser1_tx, laser2_tx}));
        check_int("rx data", 0, int'({rx_data1, rx_data2}));
        end_test();

        begin_test("loopback_fixed");
        send_pair(8'h55, 8'hAA, 1'b0);
        wait_received();
        check_int("tx_busy cycles", FRAME_CYCLES, busy_cycles);
        check_int("tx_done pulses", 1, done_count);
        end_test();

        begin_test("random_stream");
        for (int i = 0; i < 20; i++) begin
            random_byte(d1);
            random_byte(d2);
            send_pair(d1, d2, i[0]);
        end
        wait_received();
        check_int("tx_done pulses", 20, done_count);
        end_test();

        // Stop bit high on lane 1, then a clean frame
        begin_test("framing_error");
        loopback = 1'b0;
        drive_frames(make_frame(8'h3C, laser_link_pkg::START_LEVEL, !laser_link_pkg::STOP_LEVEL),
            make_frame(8'hC3, laser_link_pkg::START_LEVEL, laser_link_pkg::STOP_LEVEL), NO_GLITCH);
        drive_frames(make_frame(8'h81, laser_link_pkg::START_LEVEL, laser_link_pkg::STOP_LEVEL),
            make_frame(8'h7E, laser_link_pkg::START_LEVEL, laser_link_pkg::STOP_LEVEL), NO_GLITCH);
        wait_received();
        end_test();

        begin_test("single_lane");
        random_byte(d1);
        drive_frames(make_frame(d1, laser_link_pkg::START_LEVEL, laser_link_pkg::STOP_LEVEL),
            '0, NO_GLITCH);
        wait_received();
        end_test();

        // Flip frame bit 3, which is data bit 2 of lane 1
        begin_test("glitch");
        drive_frames(make_frame(8'hA5, laser_link_pkg::START_LEVEL, laser_link_pkg::STOP_LEVEL),
            make_frame(8'h5A, laser_link_pkg::START_LEVEL, laser_link_pkg::STOP_LEVEL), 3);
        wait_received();
        end_test();

        // Receiver stays off the line so the partial frame is not seen
        begin_test("en_abort");
        tx_data1 = 8'hFF;
        tx_data2 = 8'hFF;
        tx_start = 1'b1;
        @(negedge clock);
        tx_start = 1'b0;
        repeat (3 * laser_link_pkg::BIT_TICKS) @(negedge clock);
        check_int("laser1_tx mid-frame", 1, int'(laser1_tx));
        en = 1'b0;
        @(negedge clock);
        check_int("tx_busy after en low", 0, int'(tx_busy));
        check_int("lasers after en low", 0, int'({laser1_tx, laser2_tx}));
        tx_start = 1'b1;
        repeat (4) begin
            @(negedge clock);
            check_int("tx_busy with en low", 0, int'(tx_busy));
        end
        tx_start = 1'b0;
        // Past the point where the aborted frame would have ended
        repeat (FRAME_CYCLES) @(negedge clock);
        check_int("tx_done pulses", 0, done_count);
        en = 1'b1;
        loopback = 1'b1;
        repeat (IDLE_GAP) @(negedge clock);
        end_test();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- laser_link.f
laser_link_pkg.sv
bit_timing_if.sv
bit_timer.sv
tx_sequencer.sv
frame_serializer.sv
rx_lane_sampler.sv
rx_framer.sv
laser_link.sv
laser_link_tb.sv

//--- run_sim.sh
#!/bin/bash
# Build the laser link testbench with Verilator, run it and scan the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module laser_link_tb \
    -f laser_link.f -o laser_link_sim \
    && ./obj_dir/laser_link_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
